// ==== design/rvv_isa_pkg.sv ====
// vector ISA field encodings shared by the ALU datapath and its testbench
// import where funct3 categories or OPM funct6 codes are decoded
`default_nettype none

package rvv_isa_pkg;

  // instruction field widths
  parameter int FUNCT3_W = 3;
  parameter int FUNCT6_W = 6;

  // funct3 category of an OP-V instruction
  typedef enum logic [FUNCT3_W-1:0] {
    OPIVV = 3'b000,
    OPFVV = 3'b001,
    OPMVV = 3'b010,
    OPIVI = 3'b011,
    OPIVX = 3'b100,
    OPFVF = 3'b101,
    OPMVX = 3'b110,
    OPCFG = 3'b111
  } funct3_e;

  // mask-register logical ops under OPM
  typedef enum logic [FUNCT6_W-1:0] {
    VMANDN = 6'b011000,
    VMAND  = 6'b011001,
    VMOR   = 6'b011010,
    VMXOR  = 6'b011011,
    VMORN  = 6'b011100,
    VMNAND = 6'b011101,
    VMNOR  = 6'b011110,
    VMXNOR = 6'b011111
  } opm_funct6_e;

endpackage

`default_nettype wire

// ==== design/rvv_uarch_pkg.sv ====
// micro-architecture types and default sizes for the vector ALU slice
`default_nettype none

package rvv_uarch_pkg;

  // default sizing, overridden through the top-level parameters
  parameter int DEFAULT_VLEN      = 128;
  parameter int DEFAULT_ROB_DEPTH = 16;

  // register file targeted by a writeback
  typedef enum logic [0:0] {
    VRF = 1'b0,
    XRF = 1'b1
  } w_type_e;

endpackage

`default_nettype wire

// ==== design/rvv_alu_rs.sv ====
// in-order reservation queue for ALU uops
// the head issues whenever the queue holds an entry and the ALU is not stalled
`timescale 1ns/1ps
`default_nettype none

module rvv_alu_rs #(
  parameter int  VLEN      = rvv_uarch_pkg::DEFAULT_VLEN,
  parameter int  ROB_DEPTH = rvv_uarch_pkg::DEFAULT_ROB_DEPTH,
  parameter int  RS_DEPTH  = 4,
  localparam int ROB_W     = $clog2(ROB_DEPTH),
  localparam int VSTART_W  = $clog2(VLEN) + 1
) (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic                              uop_valid,
  input  logic [ROB_W-1:0]                  uop_rob_entry,
  input  logic [rvv_isa_pkg::FUNCT3_W-1:0]  uop_funct3,
  input  logic [rvv_isa_pkg::FUNCT6_W-1:0]  uop_funct6,
  input  logic                              uop_vm,
  input  logic [VSTART_W-1:0]               uop_vstart,
  input  logic [VLEN-1:0]                   uop_vd_data,
  input  logic [VLEN-1:0]                   uop_vs1_data,
  input  logic [VLEN-1:0]                   uop_vs2_data,
  input  logic                              alu_stall,
  output logic                              rs_full,
  output logic                              iss_valid,
  output logic [ROB_W-1:0]                  iss_rob_entry,
  output logic [rvv_isa_pkg::FUNCT3_W-1:0]  iss_funct3,
  output logic [rvv_isa_pkg::FUNCT6_W-1:0]  iss_funct6,
  output logic                              iss_vm,
  output logic [VSTART_W-1:0]               iss_vstart,
  output logic [VLEN-1:0]                   iss_vd_data,
  output logic [VLEN-1:0]                   iss_vs1_data,
  output logic [VLEN-1:0]                   iss_vs2_data
);

  localparam int PTR_W = $clog2(RS_DEPTH);
  localparam int CNT_W = $clog2(RS_DEPTH + 1);

  // one array per uop field
  logic [ROB_W-1:0]                  rob_entry_q [RS_DEPTH];
  logic [rvv_isa_pkg::FUNCT3_W-1:0]  funct3_q    [RS_DEPTH];
  logic [rvv_isa_pkg::FUNCT6_W-1:0]  funct6_q    [RS_DEPTH];
  logic                              vm_q        [RS_DEPTH];
  logic [VSTART_W-1:0]               vstart_q    [RS_DEPTH];
  logic [VLEN-1:0]                   vd_q        [RS_DEPTH];
  logic [VLEN-1:0]                   vs1_q       [RS_DEPTH];
  logic [VLEN-1:0]                   vs2_q       [RS_DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             push;
  logic             pop;

  // depth need not be a power of two
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(RS_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign rs_full   = (count == CNT_W'(RS_DEPTH));
  assign push      = uop_valid & ~rs_full;
  assign pop       = (count != '0) & ~alu_stall;
  assign iss_valid = pop;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= ptr_inc(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= ptr_inc(rd_ptr);
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      rob_entry_q[wr_ptr] <= uop_rob_entry;
      funct3_q[wr_ptr]    <= uop_funct3;
      funct6_q[wr_ptr]    <= uop_funct6;
      vm_q[wr_ptr]        <= uop_vm;
      vstart_q[wr_ptr]    <= uop_vstart;
      vd_q[wr_ptr]        <= uop_vd_data;
      vs1_q[wr_ptr]       <= uop_vs1_data;
      vs2_q[wr_ptr]       <= uop_vs2_data;
    end
  end

  // head entry feeds the ALU directly
  assign iss_rob_entry = rob_entry_q[rd_ptr];
  assign iss_funct3    = funct3_q[rd_ptr];
  assign iss_funct6    = funct6_q[rd_ptr];
  assign iss_vm        = vm_q[rd_ptr];
  assign iss_vstart    = vstart_q[rd_ptr];
  assign iss_vd_data   = vd_q[rd_ptr];
  assign iss_vs1_data  = vs1_q[rd_ptr];
  assign iss_vs2_data  = vs2_q[rd_ptr];

  // dispatch side must respect rs_full
  a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n)
    uop_valid |-> !rs_full)
    else $error("uop pushed while ALU reservation queue is full");

endmodule

`default_nettype wire

// ==== design/rvv_alu_unit.sv ====
// combinational ALU for the mask-register logical ops
// decodes the issued uop and returns its result in the same cycle
`timescale 1ns/1ps
`default_nettype none

module rvv_alu_unit #(
  parameter int  VLEN      = rvv_uarch_pkg::DEFAULT_VLEN,
  parameter int  ROB_DEPTH = rvv_uarch_pkg::DEFAULT_ROB_DEPTH,
  localparam int ROB_W     = $clog2(ROB_DEPTH),
  localparam int VSTART_W  = $clog2(VLEN) + 1
) (
  input  logic                              iss_valid,
  input  logic [ROB_W-1:0]                  iss_rob_entry,
  input  logic [rvv_isa_pkg::FUNCT3_W-1:0]  iss_funct3,
  input  logic [rvv_isa_pkg::FUNCT6_W-1:0]  iss_funct6,
  input  logic                              iss_vm,
  input  logic [VSTART_W-1:0]               iss_vstart,
  input  logic [VLEN-1:0]                   iss_vd_data,
  input  logic [VLEN-1:0]                   iss_vs1_data,
  input  logic [VLEN-1:0]                   iss_vs2_data,
  output logic                              res_valid,
  output logic [ROB_W-1:0]                  res_rob_entry,
  output logic [VLEN-1:0]                   res_data,
  output rvv_uarch_pkg::w_type_e            res_w_type
);

  import rvv_isa_pkg::*;
  import rvv_uarch_pkg::*;

  // which shared term feeds the result
  typedef enum logic [1:0] {
    SEL_AND = 2'd0,
    SEL_OR  = 2'd1,
    SEL_XOR = 2'd2
  } logic_sel_e;

  logic       is_opm;
  logic       op_known;
  logic       inv_src1;
  logic       inv_res;
  logic_sel_e sel;

  logic [VLEN-1:0] src1;
  logic [VLEN-1:0] src2;
  logic [VLEN-1:0] and_term;
  logic [VLEN-1:0] or_term;
  logic [VLEN-1:0] xor_term;
  logic [VLEN-1:0] raw;
  logic [VLEN-1:0] logic_res;
  logic [VLEN-1:0] prefix_mask;

  // OPI and OPF categories are not handled here
  assign is_opm = (funct3_e'(iss_funct3) == OPMVV) || (funct3_e'(iss_funct3) == OPMVX);

  // eight ops collapse onto three controls
  always_comb begin
    op_known = 1'b1;
    inv_src1 = 1'b0;
    inv_res  = 1'b0;
    sel      = SEL_AND;
    case (opm_funct6_e'(iss_funct6))
      VMANDN: inv_src1 = 1'b1;
      VMAND:  sel = SEL_AND;
      VMOR:   sel = SEL_OR;
      VMXOR:  sel = SEL_XOR;
      VMORN: begin
        sel      = SEL_OR;
        inv_src1 = 1'b1;
      end
      VMNAND: inv_res = 1'b1;
      VMNOR: begin
        sel     = SEL_OR;
        inv_res = 1'b1;
      end
      VMXNOR: begin
        sel     = SEL_XOR;
        inv_res = 1'b1;
      end
      default: op_known = 1'b0;
    endcase
  end

  // masked variants are illegal for mask-logical ops
  assign res_valid = iss_valid & is_opm & op_known & iss_vm;

  // operands held at zero unless a result is produced
  assign src2 = res_valid ? iss_vs2_data : '0;
  assign src1 = res_valid ? (inv_src1 ? ~iss_vs1_data : iss_vs1_data) : '0;

  assign and_term = src2 & src1;
  assign or_term  = src2 | src1;
  assign xor_term = src2 ^ src1;

  always_comb begin
    case (sel)
      SEL_OR:  raw = or_term;
      SEL_XOR: raw = xor_term;
      default: raw = and_term;
    endcase
  end

  assign logic_res = inv_res ? ~raw : raw;

  // bits below vstart keep the old destination value
  assign prefix_mask = ~({VLEN{1'b1}} << iss_vstart);
  assign res_data    = (prefix_mask & iss_vd_data) | (~prefix_mask & logic_res);

  assign res_rob_entry = iss_rob_entry;
  assign res_w_type    = VRF;

endmodule

`default_nettype wire

// ==== design/rvv_rob_wb.sv ====
// writeback register toward the ROB and the per-entry completion bitmap
// a retire strobe clears one bit, a same-cycle writeback to that entry wins
`timescale 1ns/1ps
`default_nettype none

module rvv_rob_wb #(
  parameter int  VLEN      = rvv_uarch_pkg::DEFAULT_VLEN,
  parameter int  ROB_DEPTH = rvv_uarch_pkg::DEFAULT_ROB_DEPTH,
  localparam int ROB_W     = $clog2(ROB_DEPTH)
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    res_valid,
  input  logic [ROB_W-1:0]        res_rob_entry,
  input  logic [VLEN-1:0]         res_data,
  input  rvv_uarch_pkg::w_type_e  res_w_type,
  input  logic                    retire_valid,
  input  logic [ROB_W-1:0]        retire_entry,
  output logic                    wb_valid,
  output logic [ROB_W-1:0]        wb_rob_entry,
  output logic [VLEN-1:0]         wb_data,
  output rvv_uarch_pkg::w_type_e  wb_w_type,
  output logic [ROB_DEPTH-1:0]    done_mask
);

  logic [ROB_DEPTH-1:0] done_next;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wb_valid <= 1'b0;
    end else begin
      wb_valid <= res_valid;
    end
  end

  // payload only loads with a valid result
  always_ff @(posedge clk) begin
    if (res_valid) begin
      wb_rob_entry <= res_rob_entry;
      wb_data      <= res_data;
      wb_w_type    <= res_w_type;
    end
  end

  // set applied after clear so it takes priority
  always_comb begin
    done_next = done_mask;
    if (retire_valid) begin
      done_next[retire_entry] = 1'b0;
    end
    if (res_valid) begin
      done_next[res_rob_entry] = 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      done_mask <= '0;
    end else begin
      done_mask <= done_next;
    end
  end

  // an entry completes once between retires
  a_no_double_set: assert property (@(posedge clk) disable iff (!rst_n)
    (res_valid && !(retire_valid && retire_entry == res_rob_entry))
      |-> !done_mask[res_rob_entry])
    else $error("writeback to ROB entry %0d already marked done", res_rob_entry);

endmodule

`default_nettype wire

// ==== design/rvv_alu_subsys.sv ====
// vector ALU slice: reservation queue, mask-logic ALU and ROB writeback
// sizing is set here and passed to every block
`timescale 1ns/1ps
`default_nettype none

module rvv_alu_subsys #(
  parameter int  VLEN      = rvv_uarch_pkg::DEFAULT_VLEN,
  parameter int  ROB_DEPTH = rvv_uarch_pkg::DEFAULT_ROB_DEPTH,
  parameter int  RS_DEPTH  = 4,
  localparam int ROB_W     = $clog2(ROB_DEPTH),
  localparam int VSTART_W  = $clog2(VLEN) + 1
) (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic                              uop_valid,
  input  logic [ROB_W-1:0]                  uop_rob_entry,
  input  logic [rvv_isa_pkg::FUNCT3_W-1:0]  uop_funct3,
  input  logic [rvv_isa_pkg::FUNCT6_W-1:0]  uop_funct6,
  input  logic                              uop_vm,
  input  logic [VSTART_W-1:0]               uop_vstart,
  input  logic [VLEN-1:0]                   uop_vd_data,
  input  logic [VLEN-1:0]                   uop_vs1_data,
  input  logic [VLEN-1:0]                   uop_vs2_data,
  input  logic                              alu_stall,
  input  logic                              retire_valid,
  input  logic [ROB_W-1:0]                  retire_entry,
  output logic                              rs_full,
  output logic                              wb_valid,
  output logic [ROB_W-1:0]                  wb_rob_entry,
  output logic [VLEN-1:0]                   wb_data,
  output rvv_uarch_pkg::w_type_e            wb_w_type,
  output logic [ROB_DEPTH-1:0]              done_mask
);

  import rvv_isa_pkg::*;
  import rvv_uarch_pkg::*;

  // queue head to ALU
  logic                iss_valid;
  logic [ROB_W-1:0]    iss_rob_entry;
  logic [FUNCT3_W-1:0] iss_funct3;
  logic [FUNCT6_W-1:0] iss_funct6;
  logic                iss_vm;
  logic [VSTART_W-1:0] iss_vstart;
  logic [VLEN-1:0]     iss_vd_data;
  logic [VLEN-1:0]     iss_vs1_data;
  logic [VLEN-1:0]     iss_vs2_data;

  // ALU to writeback
  logic                res_valid;
  logic [ROB_W-1:0]    res_rob_entry;
  logic [VLEN-1:0]     res_data;
  w_type_e             res_w_type;

  rvv_alu_rs #(
    .VLEN      (VLEN),
    .ROB_DEPTH (ROB_DEPTH),
    .RS_DEPTH  (RS_DEPTH)
  ) u_alu_rs (
    .clk           (clk),
    .rst_n         (rst_n),
    .uop_valid     (uop_valid),
    .uop_rob_entry (uop_rob_entry),
    .uop_funct3    (uop_funct3),
    .uop_funct6    (uop_funct6),
    .uop_vm        (uop_vm),
    .uop_vstart    (uop_vstart),
    .uop_vd_data   (uop_vd_data),
    .uop_vs1_data  (uop_vs1_data),
    .uop_vs2_data  (uop_vs2_data),
    .alu_stall     (alu_stall),
    .rs_full       (rs_full),
    .iss_valid     (iss_valid),
    .iss_rob_entry (iss_rob_entry),
    .iss_funct3    (iss_funct3),
    .iss_funct6    (iss_funct6),
    .iss_vm        (iss_vm),
    .iss_vstart    (iss_vstart),
    .iss_vd_data   (iss_vd_data),
    .iss_vs1_data  (iss_vs1_data),
    .iss_vs2_data  (iss_vs2_data)
  );

  rvv_alu_unit #(
    .VLEN      (VLEN),
    .ROB_DEPTH (ROB_DEPTH)
  ) u_alu_unit (
    .iss_valid     (iss_valid),
    .iss_rob_entry (iss_rob_entry),
    .iss_funct3    (iss_funct3),
    .iss_funct6    (iss_funct6),
    .iss_vm        (iss_vm),
    .iss_vstart    (iss_vstart),
    .iss_vd_data   (iss_vd_data),
    .iss_vs1_data  (iss_vs1_data),
    .iss_vs2_data  (iss_vs2_data),
    .res_valid     (res_valid),
    .res_rob_entry (res_rob_entry),
    .res_data      (res_data),
    .res_w_type    (res_w_type)
  );

  rvv_rob_wb #(
    .VLEN      (VLEN),
    .ROB_DEPTH (ROB_DEPTH)
  ) u_rob_wb (
    .clk           (clk),
    .rst_n         (rst_n),
    .res_valid     (res_valid),
    .res_rob_entry (res_rob_entry),
    .res_data      (res_data),
    .res_w_type    (res_w_type),
    .retire_valid  (retire_valid),
    .retire_entry  (retire_entry),
    .wb_valid      (wb_valid),
    .wb_rob_entry  (wb_rob_entry),
    .wb_data       (wb_data),
    .wb_w_type     (wb_w_type),
    .done_mask     (done_mask)
  );

endmodule

`default_nettype wire

// ==== dv/rvv_alu_subsys_tb.sv ====
// random-stimulus testbench for the vector ALU slice
// a model queue predicts every writeback and the completion bitmap
`timescale 1ns/1ps
`default_nettype none

module rvv_alu_subsys_tb;

  import rvv_isa_pkg::*;
  import rvv_uarch_pkg::*;

  localparam int VLEN      = 128;
  localparam int ROB_DEPTH = 16;
  localparam int RS_DEPTH  = 4;
  localparam int ROB_W     = $clog2(ROB_DEPTH);
  localparam int VSTART_W  = $clog2(VLEN) + 1;
  localparam int TIMEOUT   = 64;

  typedef struct packed {
    logic             drop;
    logic [ROB_W-1:0] entry;
    logic [VLEN-1:0]  data;
  } exp_t;

  logic                 clk;
  logic                 rst_n;
  logic                 uop_valid;
  logic [ROB_W-1:0]     uop_rob_entry;
  logic [FUNCT3_W-1:0]  uop_funct3;
  logic [FUNCT6_W-1:0]  uop_funct6;
  logic                 uop_vm;
  logic [VSTART_W-1:0]  uop_vstart;
  logic [VLEN-1:0]      uop_vd_data;
  logic [VLEN-1:0]      uop_vs1_data;
  logic [VLEN-1:0]      uop_vs2_data;
  logic                 alu_stall;
  logic                 retire_valid;
  logic [ROB_W-1:0]     retire_entry;
  logic                 rs_full;
  logic                 wb_valid;
  logic [ROB_W-1:0]     wb_rob_entry;
  logic [VLEN-1:0]      wb_data;
  w_type_e              wb_w_type;
  logic [ROB_DEPTH-1:0] done_mask;

  // model state
  exp_t                 exp_q[$];
  logic [ROB_DEPTH-1:0] model_done = '0;
  logic                 retire_pend = 1'b0;
  logic [ROB_W-1:0]     retire_pend_entry = '0;
  logic [ROB_W-1:0]     next_entry = '0;
  int                   pending_cnt = 0;
  int                   wb_count = 0;
  int                   cycle = 0;
  int                   last_push_cycle = 0;
  int                   last_wb_cycle = 0;

  rvv_alu_subsys #(
    .VLEN      (VLEN),
    .ROB_DEPTH (ROB_DEPTH),
    .RS_DEPTH  (RS_DEPTH)
  ) DUT (
    .clk           (clk),
    .rst_n         (rst_n),
    .uop_valid     (uop_valid),
    .uop_rob_entry (uop_rob_entry),
    .uop_funct3    (uop_funct3),
    .uop_funct6    (uop_funct6),
    .uop_vm        (uop_vm),
    .uop_vstart    (uop_vstart),
    .uop_vd_data   (uop_vd_data),
    .uop_vs1_data  (uop_vs1_data),
    .uop_vs2_data  (uop_vs2_data),
    .alu_stall     (alu_stall),
    .retire_valid  (retire_valid),
    .retire_entry  (retire_entry),
    .rs_full       (rs_full),
    .wb_valid      (wb_valid),
    .wb_rob_entry  (wb_rob_entry),
    .wb_data       (wb_data),
    .wb_w_type     (wb_w_type),
    .done_mask     (done_mask)
  );

  always #20 clk = ~clk;

  always @(posedge clk) begin
    cycle++;
  end

  task automatic stop_run(input string msg);
    $display("%s", msg);
    $display("*** TEST FAILED ***");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic check_value(input string what, input logic [VLEN-1:0] actual,
                             input logic [VLEN-1:0] expected);
    if (actual !== expected) begin
      stop_run($sformatf("Fail at %0d ns: %s, got %h, expected %h",
                         $time, what, actual, expected));
    end
  endtask

  function automatic logic [VLEN-1:0] rand_vec();
    logic [VLEN-1:0] v;
    for (int i = 0; i < VLEN / 32; i++) begin
      v[i*32 +: 32] = $urandom;
    end
    return v;
  endfunction

  function automatic logic is_legal(input logic [2:0] f3, input logic [5:0] f6, input logic vm);
    return ((f3 == OPMVV) || (f3 == OPMVX)) && (f6 >= 6'b011000) && (f6 <= 6'b011111) && vm;
  endfunction

  // truth table per op, then vd fills the prefix below vstart
  function automatic logic [VLEN-1:0] expected_data(input logic [5:0] f6,
      input logic [VLEN-1:0] vd, input logic [VLEN-1:0] vs1, input logic [VLEN-1:0] vs2,
      input int vstart);
    logic [VLEN-1:0] r;
    case (f6)
      VMANDN:  r = vs2 & ~vs1;
      VMAND:   r = vs2 & vs1;
      VMOR:    r = vs2 | vs1;
      VMXOR:   r = vs2 ^ vs1;
      VMORN:   r = vs2 | ~vs1;
      VMNAND:  r = ~(vs2 & vs1);
      VMNOR:   r = ~(vs2 | vs1);
      default: r = ~(vs2 ^ vs1);
    endcase
    for (int i = 0; i < VLEN; i++) begin
      if (i < vstart) r[i] = vd[i];
    end
    return r;
  endfunction

  task automatic idle_cycle();
    @(posedge clk);
    #2;
    uop_valid    = 1'b0;
    retire_valid = 1'b0;
  endtask

  task automatic push_uop(input logic [ROB_W-1:0] entry, input logic [2:0] f3,
      input logic [5:0] f6, input logic vm, input int vstart,
      input logic [VLEN-1:0] vd, input logic [VLEN-1:0] vs1, input logic [VLEN-1:0] vs2);
    exp_t e;
    @(posedge clk);
    #2;
    if (rs_full) stop_run("tried to push a uop while the reservation queue was full");
    uop_valid     = 1'b1;
    retire_valid  = 1'b0;
    uop_rob_entry = entry;
    uop_funct3    = f3;
    uop_funct6    = f6;
    uop_vm        = vm;
    uop_vstart    = VSTART_W'(vstart);
    uop_vd_data   = vd;
    uop_vs1_data  = vs1;
    uop_vs2_data  = vs2;
    e.drop  = !is_legal(f3, f6, vm);
    e.entry = entry;
    e.data  = expected_data(f6, vd, vs1, vs2, vstart);
    exp_q.push_back(e);
    if (!e.drop) pending_cnt++;
    last_push_cycle = cycle;
  endtask

  task automatic push_legal(input logic [5:0] f6, input int vstart);
    logic [2:0] f3;
    f3 = ($urandom_range(0, 1) != 0) ? OPMVX : OPMVV;
    push_uop(next_entry, f3, f6, 1'b1, vstart, rand_vec(), rand_vec(), rand_vec());
    next_entry = next_entry + 1'b1;
  endtask

  task automatic retire_strobe(input logic [ROB_W-1:0] entry);
    @(posedge clk);
    #2;
    uop_valid    = 1'b0;
    retire_valid = 1'b1;
    retire_entry = entry;
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    while (pending_cnt != 0) begin
      if (n == TIMEOUT) stop_run("timed out waiting for outstanding writebacks");
      idle_cycle();
      n++;
    end
  endtask

  // clear every completed entry, one retire per cycle
  task automatic retire_all();
    for (int i = 0; i < ROB_DEPTH; i++) begin
      if (model_done[i]) retire_strobe(ROB_W'(i));
    end
    idle_cycle();
    idle_cycle();
    check_value("done_mask after retiring all", done_mask, '0);
  endtask

  task automatic take_writeback();
    exp_t e;
    while (exp_q.size() > 0 && exp_q[0].drop) begin
      void'(exp_q.pop_front());
    end
    if (exp_q.size() == 0) stop_run("wb_valid seen with no result expected");
    e = exp_q.pop_front();
    check_value("wb_rob_entry", wb_rob_entry, e.entry);
    check_value("wb_data", wb_data, e.data);
    check_value("wb_w_type", wb_w_type, VRF);
    model_done[e.entry] = 1'b1;
    pending_cnt--;
    wb_count++;
    last_wb_cycle = cycle;
  endtask

  // outputs sampled mid-cycle, retire seen last cycle is applied before the set
  always @(negedge clk) begin
    if (rst_n) begin
      if (retire_pend) model_done[retire_pend_entry] = 1'b0;
      if (wb_valid) take_writeback();
      check_value("done_mask", done_mask, model_done);
      retire_pend       = retire_valid;
      retire_pend_entry = retire_entry;
    end
  end

  initial begin
    int              start;
    int              wb_before;
    logic [5:0]      f6;
    logic [2:0]      f3;
    logic [ROB_W-1:0] e;
    logic [2:0]      bad_f3 [6];
    void'($urandom(32'h28d3_503d));
    bad_f3 = '{OPIVV, OPFVV, OPIVI, OPIVX, OPFVF, OPCFG};
    clk           = 1'b0;
    rst_n         = 1'b0;
    uop_valid     = 1'b0;
    uop_rob_entry = '0;
    uop_funct3    = '0;
    uop_funct6    = '0;
    uop_vm        = 1'b0;
    uop_vstart    = '0;
    uop_vd_data   = '0;
    uop_vs1_data  = '0;
    uop_vs2_data  = '0;
    alu_stall     = 1'b0;
    retire_valid  = 1'b0;
    retire_entry  = '0;
    repeat (2) @(posedge clk);
    #2;
    rst_n = 1'b1;
    check_value("rs_full after reset", rs_full, '0);
    check_value("wb_valid after reset", wb_valid, '0);

    // each op alone, vstart 0, two cycles to writeback
    for (int op = 0; op < 8; op++) begin
      push_legal(6'b011000 + 6'(op), 0);
      start = last_push_cycle;
      wait_drain();
      check_value("single uop latency", VLEN'(last_wb_cycle - start), VLEN'(2));
    end
    retire_all();

    // vstart prefix, first one keeps the whole of vd
    for (int i = 0; i < 12; i++) begin
      push_legal(6'b011000 + 6'($urandom_range(0, 7)),
                 (i == 0) ? VLEN : int'($urandom_range(0, VLEN)));
    end
    wait_drain();
    retire_all();

    // illegal uops mixed with legal ones
    for (int k = 0; k < 6; k++) begin
      f3 = OPMVV;
      f6 = VMAND;
      if (k % 3 == 0) begin
        f3 = bad_f3[$urandom_range(0, 5)];
      end else if (k % 3 == 1) begin
        do f6 = 6'($urandom_range(0, 63)); while (f6 >= 6'b011000 && f6 <= 6'b011111);
      end
      push_uop(ROB_W'($urandom), f3, f6, (k % 3) != 2, $urandom_range(0, VLEN),
               rand_vec(), rand_vec(), rand_vec());
      push_legal(6'b011000 + 6'($urandom_range(0, 7)), 0);
    end
    wait_drain();
    retire_all();

    // back to back, one result per cycle
    for (int i = 0; i < 6; i++) begin
      push_legal(6'b011000 + 6'($urandom_range(0, 7)), $urandom_range(0, VLEN));
      if (i == 0) start = last_push_cycle;
    end
    wait_drain();
    check_value("back-to-back drain time", VLEN'(last_wb_cycle - start), VLEN'(7));
    retire_all();

    // stall holds the queue until it is full
    idle_cycle();
    alu_stall = 1'b1;
    wb_before = wb_count;
    for (int i = 0; i < RS_DEPTH; i++) begin
      push_legal(6'b011000 + 6'($urandom_range(0, 7)), $urandom_range(0, VLEN));
    end
    idle_cycle();
    check_value("rs_full under stall", rs_full, 1'b1);
    repeat (3) idle_cycle();
    check_value("writebacks during stall", VLEN'(wb_count - wb_before), '0);
    alu_stall = 1'b0;
    wait_drain();
    retire_all();

    // retire and set of one entry in the same cycle
    e = next_entry;
    push_legal(VMXOR, 0);
    wait_drain();
    push_uop(e, OPMVV, VMNOR, 1'b1, 0, rand_vec(), rand_vec(), rand_vec());
    retire_strobe(e);
    wait_drain();
    check_value("done bit after retire and set", done_mask[e], 1'b1);
    retire_all();

    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire

// ==== project.f ====
design/rvv_isa_pkg.sv
design/rvv_uarch_pkg.sv
design/rvv_alu_rs.sv
design/rvv_alu_unit.sv
design/rvv_rob_wb.sv
design/rvv_alu_subsys.sv
dv/rvv_alu_subsys_tb.sv

// ==== Bender.yml ====
package:
  name: rvv_alu_subsys

sources:
  - design/rvv_isa_pkg.sv
  - design/rvv_uarch_pkg.sv
  - design/rvv_alu_rs.sv
  - design/rvv_alu_unit.sv
  - design/rvv_rob_wb.sv
  - design/rvv_alu_subsys.sv
  - target: test
    files:
      - dv/rvv_alu_subsys_tb.sv
